//--- include/rv32i_settings.svh
//----------------------------------------
// RV32I core build settings
//----------------------------------------
`ifndef RV32I_SETTINGS_SVH
`define RV32I_SETTINGS_SVH

// first fetch address after reset
`define RV32I_RESET_PC 32'h0000_0000

`define RV32I_NUM_REGS 32

// byte address width on the APB side
`define RV32I_APB_ADDR_W 16

`endif

//--- rtl/alu.sv
//----------------------------------------
// ALU and branch comparator
//----------------------------------------
module alu (
    input  rv32i_pkg::alu_ops         i_aluop,
    input  rv32i_pkg::rv32i_word      i_a,
    input  rv32i_pkg::rv32i_word      i_b,
    input  rv32i_pkg::branch_funct3_t i_cmpop,
    input  rv32i_pkg::rv32i_word      i_cmp_a,
    input  rv32i_pkg::rv32i_word      i_cmp_b,
    output rv32i_pkg::rv32i_word      o_result,
    output logic                      o_br_en
);
    import rv32i_pkg::*;

    logic [4:0] shamt;

    assign shamt = i_b[4:0];

    always_comb begin
        case (i_aluop)
            alu_add: o_result = i_a + i_b;
            alu_sll: o_result = i_a << shamt;
            alu_sra: o_result = rv32i_word'($signed(i_a) >>> shamt);
            alu_sub: o_result = i_a - i_b;
            alu_xor: o_result = i_a ^ i_b;
            alu_srl: o_result = i_a >> shamt;
            alu_or:  o_result = i_a | i_b;
            default: o_result = i_a & i_b;
        endcase
    end

    // also drives slt/sltu through blt/bltu
    always_comb begin
        case (i_cmpop)
            beq:     o_br_en = (i_cmp_a == i_cmp_b);
            bne:     o_br_en = (i_cmp_a != i_cmp_b);
            blt:     o_br_en = ($signed(i_cmp_a) < $signed(i_cmp_b));
            bge:     o_br_en = ($signed(i_cmp_a) >= $signed(i_cmp_b));
            bltu:    o_br_en = (i_cmp_a < i_cmp_b);
            bgeu:    o_br_en = (i_cmp_a >= i_cmp_b);
            default: o_br_en = 1'b0;
        endcase
    end

endmodule

//--- rtl/apb_mem_port.sv
//----------------------------------------
// APB requester for fetch, load and store
//----------------------------------------
`include "rv32i_settings.svh"

module apb_mem_port (
    input  logic                         clk,
    input  logic                         i_reset,
    input  logic                         i_req,
    input  logic                         i_write,
    input  logic [`RV32I_APB_ADDR_W-1:0] i_addr,
    input  logic [2:0]                   i_funct3,
    input  rv32i_pkg::rv32i_word         i_wdata,
    output logic                         o_done,
    output rv32i_pkg::rv32i_word         o_rdata,
    output logic                         o_psel,
    output logic                         o_penable,
    output logic                         o_pwrite,
    output logic [`RV32I_APB_ADDR_W-1:0] o_paddr,
    output rv32i_pkg::rv32i_word         o_pwdata,
    output logic [3:0]                   o_pstrb,
    input  rv32i_pkg::rv32i_word         i_prdata,
    input  logic                         i_pready
);
    import rv32i_pkg::*;

    typedef enum logic [1:0] {st_idle, st_setup, st_access} apb_state_t;

    apb_state_t state;
    logic [3:0] strb;

    // byte lanes from the low address bits
    always_comb begin
        case (store_funct3_t'(i_funct3))
            sb:      strb = 4'b0001 << i_addr[1:0];
            sh:      strb = 4'b0011 << {i_addr[1], 1'b0};
            default: strb = 4'b1111;
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            state    <= st_idle;
            o_pwrite <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (i_req) begin
                        state    <= st_setup;
                        o_pwrite <= i_write;
                    end
                end
                st_setup: state <= st_access;
                default:  state <= i_pready ? st_idle : st_access;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && i_req) begin
            o_paddr  <= {i_addr[`RV32I_APB_ADDR_W-1:2], 2'b00};
            o_pwdata <= i_wdata << {i_addr[1:0], 3'b000};
            o_pstrb  <= i_write ? strb : 4'b0000;
        end
    end

    assign o_psel    = (state != st_idle);
    assign o_penable = (state == st_access);
    assign o_done    = (state == st_access) && i_pready;
    assign o_rdata   = i_prdata;

endmodule

//--- rtl/control_rom.sv
//----------------------------------------
// control ROM, turns opcode and funct
// fields into datapath selects
//----------------------------------------
module control_rom (
    input  rv32i_pkg::rv32i_opcode     i_opcode,
    input  logic [2:0]                 i_funct3,
    input  logic [6:0]                 i_funct7,
    output rv32i_pkg::alu_ops          o_aluop,
    output rv32i_pkg::alumux1_sel_t    o_alumux1_sel,
    output rv32i_pkg::alumux2_sel_t    o_alumux2_sel,
    output rv32i_pkg::branch_funct3_t  o_cmpop,
    output rv32i_pkg::cmpmux_sel_t     o_cmpmux_sel,
    output rv32i_pkg::regfilemux_sel_t o_regfilemux_sel,
    output logic                       o_load_regfile,
    output logic                       o_data_mem_read,
    output logic                       o_data_mem_write,
    output logic                       o_is_branch,
    output logic                       o_is_jump,
    output logic                       o_illegal
);
    import rv32i_pkg::*;

    always_comb begin
        o_aluop          = alu_add;
        o_alumux1_sel    = mux1_rs1_out;
        o_alumux2_sel    = mux2_i_imm;
        o_cmpop          = beq;
        o_cmpmux_sel     = cmp_rs2_out;
        o_regfilemux_sel = rf_alu_out;
        o_load_regfile   = 1'b0;
        o_data_mem_read  = 1'b0;
        o_data_mem_write = 1'b0;
        o_is_branch      = 1'b0;
        o_is_jump        = 1'b0;
        o_illegal        = 1'b0;

        case (i_opcode)
            op_lui: begin
                o_load_regfile   = 1'b1;
                o_regfilemux_sel = rf_u_imm;
            end
            op_auipc: begin
                o_alumux1_sel  = mux1_pc_out;
                o_alumux2_sel  = mux2_u_imm;
                o_load_regfile = 1'b1;
            end
            op_jal, op_jalr: begin
                // jal adds to pc, jalr to rs1
                o_alumux1_sel    = (i_opcode == op_jal) ? mux1_pc_out : mux1_rs1_out;
                o_alumux2_sel    = (i_opcode == op_jal) ? mux2_j_imm : mux2_i_imm;
                o_is_jump        = 1'b1;
                o_load_regfile   = 1'b1;
                o_regfilemux_sel = rf_pc_plus4;
            end
            op_br: begin
                // target from the ALU, condition from the comparator
                o_alumux1_sel = mux1_pc_out;
                o_alumux2_sel = mux2_b_imm;
                o_cmpop       = branch_funct3_t'(i_funct3);
                o_is_branch   = 1'b1;
                o_illegal     = (i_funct3[2:1] == 2'b01);
            end
            op_load: begin
                o_data_mem_read = 1'b1;
                o_load_regfile  = 1'b1;
                case (load_funct3_t'(i_funct3))
                    lb:      o_regfilemux_sel = rf_lb;
                    lh:      o_regfilemux_sel = rf_lh;
                    lw:      o_regfilemux_sel = rf_lw;
                    lbu:     o_regfilemux_sel = rf_lbu;
                    lhu:     o_regfilemux_sel = rf_lhu;
                    default: o_illegal = 1'b1;
                endcase
            end
            op_store: begin
                o_alumux2_sel    = mux2_s_imm;
                o_data_mem_write = 1'b1;
                o_illegal        = (i_funct3 > 3'd2);
            end
            op_imm, op_reg: begin
                o_alumux2_sel  = (i_opcode == op_imm) ? mux2_i_imm : mux2_rs2_out;
                o_cmpmux_sel   = (i_opcode == op_imm) ? cmp_i_imm : cmp_rs2_out;
                o_load_regfile = 1'b1;
                case (arith_funct3_t'(i_funct3))
                    // sub exists only in the register form
                    add:  o_aluop = (i_opcode == op_reg && i_funct7[5]) ? alu_sub : alu_add;
                    sll:  o_aluop = alu_sll;
                    slt: begin
                        o_cmpop          = blt;
                        o_regfilemux_sel = rf_br_en;
                    end
                    sltu: begin
                        o_cmpop          = bltu;
                        o_regfilemux_sel = rf_br_en;
                    end
                    axor: o_aluop = alu_xor;
                    sr:   o_aluop = i_funct7[5] ? alu_sra : alu_srl;
                    aor:  o_aluop = alu_or;
                    default: o_aluop = alu_and;
                endcase
            end
            default: o_illegal = 1'b1;
        endcase
    end

endmodule

//--- rtl/regfile.sv
//----------------------------------------
// register file, 2 read and 1 write port
//----------------------------------------
`include "rv32i_settings.svh"

module regfile (
    input  logic                 clk,
    input  logic                 i_reset,
    input  logic                 i_load,
    input  rv32i_pkg::rv32i_reg  i_rd,
    input  rv32i_pkg::rv32i_word i_rd_data,
    input  rv32i_pkg::rv32i_reg  i_rs1,
    input  rv32i_pkg::rv32i_reg  i_rs2,
    output rv32i_pkg::rv32i_word o_rs1_data,
    output rv32i_pkg::rv32i_word o_rs2_data
);
    import rv32i_pkg::*;

    rv32i_word regs [`RV32I_NUM_REGS];

    always_ff @(posedge clk) begin
        if (i_reset) begin
            for (int i = 0; i < `RV32I_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_load && i_rd != '0) begin
            regs[i_rd] <= i_rd_data;
        end
    end

    // x0 never written, so it reads back zero
    assign o_rs1_data = regs[i_rs1];
    assign o_rs2_data = regs[i_rs2];

endmodule

//--- rtl/rv32i_core.sv
//----------------------------------------
// multicycle RV32I core with one APB port
//----------------------------------------
`include "rv32i_settings.svh"

module rv32i_core (
    input  logic                         clk,
    input  logic                         i_reset,
    output logic                         o_psel,
    output logic                         o_penable,
    output logic                         o_pwrite,
    output logic [`RV32I_APB_ADDR_W-1:0] o_paddr,
    output rv32i_pkg::rv32i_word         o_pwdata,
    output logic [3:0]                   o_pstrb,
    input  rv32i_pkg::rv32i_word         i_prdata,
    input  logic                         i_pready,
    output logic                         o_halted
);
    import rv32i_pkg::*;

    core_phase_t phase;
    logic mem_busy, mem_req, mem_done, br_q, br_en;
    rv32i_word pc, ir, alu_q, mdr, mem_rdata, pc_plus4, next_pc, load_shifted;
    rv32i_word imm_i, imm_s, imm_b, imm_u, imm_j;
    rv32i_word rs1_data, rs2_data, rd_data, alu_a, alu_b, cmp_b, alu_result;
    logic [`RV32I_APB_ADDR_W-1:0] mem_addr;

    alu_ops aluop;
    alumux1_sel_t alumux1_sel;
    alumux2_sel_t alumux2_sel;
    branch_funct3_t cmpop;
    cmpmux_sel_t cmpmux_sel;
    regfilemux_sel_t regfilemux_sel;
    logic load_regfile, data_mem_read, data_mem_write, is_branch, is_jump, illegal;

    assign imm_i = {{21{ir[31]}}, ir[30:20]};
    assign imm_s = {{21{ir[31]}}, ir[30:25], ir[11:7]};
    assign imm_b = {{20{ir[31]}}, ir[7], ir[30:25], ir[11:8], 1'b0};
    assign imm_u = {ir[31:12], 12'h000};
    assign imm_j = {{12{ir[31]}}, ir[19:12], ir[20], ir[30:21], 1'b0};

    control_rom u_control_rom (
        .i_opcode(rv32i_opcode'(ir[6:0])), .i_funct3(ir[14:12]), .i_funct7(ir[31:25]),
        .o_aluop(aluop), .o_alumux1_sel(alumux1_sel), .o_alumux2_sel(alumux2_sel),
        .o_cmpop(cmpop), .o_cmpmux_sel(cmpmux_sel), .o_regfilemux_sel(regfilemux_sel),
        .o_load_regfile(load_regfile), .o_data_mem_read(data_mem_read),
        .o_data_mem_write(data_mem_write), .o_is_branch(is_branch), .o_is_jump(is_jump),
        .o_illegal(illegal)
    );

    regfile u_regfile (
        .clk(clk), .i_reset(i_reset), .i_load(phase == writeback && load_regfile),
        .i_rd(ir[11:7]), .i_rd_data(rd_data), .i_rs1(ir[19:15]), .i_rs2(ir[24:20]),
        .o_rs1_data(rs1_data), .o_rs2_data(rs2_data)
    );

    assign alu_a = (alumux1_sel == mux1_pc_out) ? pc : rs1_data;
    assign cmp_b = (cmpmux_sel == cmp_i_imm) ? imm_i : rs2_data;

    always_comb begin
        case (alumux2_sel)
            mux2_u_imm: alu_b = imm_u;
            mux2_b_imm: alu_b = imm_b;
            mux2_s_imm: alu_b = imm_s;
            mux2_j_imm: alu_b = imm_j;
            mux2_rs2_out: alu_b = rs2_data;
            default: alu_b = imm_i;
        endcase
    end

    alu u_alu (
        .i_aluop(aluop), .i_a(alu_a), .i_b(alu_b), .i_cmpop(cmpop),
        .i_cmp_a(rs1_data), .i_cmp_b(cmp_b), .o_result(alu_result), .o_br_en(br_en)
    );

    // one request per fetch or memory phase
    assign mem_req  = (phase == fetch || phase == memory) && !mem_busy;
    assign mem_addr = (phase == memory) ? alu_q[`RV32I_APB_ADDR_W-1:0]
                                        : pc[`RV32I_APB_ADDR_W-1:0];

    apb_mem_port u_apb_mem_port (
        .clk(clk), .i_reset(i_reset), .i_req(mem_req),
        .i_write(phase == memory && data_mem_write), .i_addr(mem_addr),
        .i_funct3(ir[14:12]), .i_wdata(rs2_data), .o_done(mem_done), .o_rdata(mem_rdata),
        .o_psel(o_psel), .o_penable(o_penable), .o_pwrite(o_pwrite), .o_paddr(o_paddr),
        .o_pwdata(o_pwdata), .o_pstrb(o_pstrb), .i_prdata(i_prdata), .i_pready(i_pready)
    );

    assign pc_plus4 = pc + 32'd4;
    // jalr needs bit 0 cleared, other targets are already even
    assign next_pc  = (is_jump || (is_branch && br_q)) ? {alu_q[31:1], 1'b0} : pc_plus4;

    // load lane moved down to bit 0
    assign load_shifted = mdr >> {alu_q[1:0], 3'b000};

    always_comb begin
        case (regfilemux_sel)
            rf_br_en:    rd_data = {31'b0, br_q};
            rf_u_imm:    rd_data = imm_u;
            rf_lw:       rd_data = mdr;
            rf_pc_plus4: rd_data = pc_plus4;
            rf_lb:       rd_data = {{24{load_shifted[7]}}, load_shifted[7:0]};
            rf_lbu:      rd_data = {24'b0, load_shifted[7:0]};
            rf_lh:       rd_data = {{16{load_shifted[15]}}, load_shifted[15:0]};
            rf_lhu:      rd_data = {16'b0, load_shifted[15:0]};
            default:     rd_data = alu_q;
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            phase    <= fetch;
            mem_busy <= 1'b0;
            pc       <= `RV32I_RESET_PC;
        end else begin
            if (mem_req) begin
                mem_busy <= 1'b1;
            end else if (mem_done) begin
                mem_busy <= 1'b0;
            end
            case (phase)
                fetch:     if (mem_done) phase <= decode;
                decode:    phase <= illegal ? halt : execute;
                execute:   phase <= (data_mem_read || data_mem_write) ? memory : writeback;
                memory:    if (mem_done) phase <= writeback;
                writeback: begin
                    pc    <= next_pc;
                    phase <= fetch;
                end
                default:   phase <= halt;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (phase == fetch && mem_done) begin
            ir <= mem_rdata;
        end
        if (phase == execute) begin
            alu_q <= alu_result;
            br_q  <= br_en;
        end
        if (phase == memory && mem_done) begin
            mdr <= mem_rdata;
        end
    end

    assign o_halted = (phase == halt);

endmodule

//--- rtl/rv32i_pkg.sv
//----------------------------------------
// RV32I shared types, instruction encodings
// and datapath select codes
//----------------------------------------
package rv32i_pkg;

    typedef logic [31:0] rv32i_word;
    typedef logic [4:0] rv32i_reg;

    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } rv32i_opcode;

    typedef enum logic [2:0] {
        beq = 3'b000, bne = 3'b001, blt = 3'b100, bge = 3'b101, bltu = 3'b110, bgeu = 3'b111
    } branch_funct3_t;

    typedef enum logic [2:0] {
        lb = 3'b000, lh = 3'b001, lw = 3'b010, lbu = 3'b100, lhu = 3'b101
    } load_funct3_t;

    typedef enum logic [2:0] {
        sb = 3'b000, sh = 3'b001, sw = 3'b010
    } store_funct3_t;

    typedef enum logic [2:0] {
        add, sll, slt, sltu, axor, sr, aor, aand
    } arith_funct3_t;

    typedef enum logic [2:0] {
        alu_add, alu_sll, alu_sra, alu_sub, alu_xor, alu_srl, alu_or, alu_and
    } alu_ops;

    // operand mux selects, prefixed to keep the literals apart
    typedef enum logic {mux1_rs1_out, mux1_pc_out} alumux1_sel_t;
    typedef enum logic [2:0] {
        mux2_i_imm, mux2_u_imm, mux2_b_imm, mux2_s_imm, mux2_j_imm, mux2_rs2_out
    } alumux2_sel_t;
    typedef enum logic {cmp_rs2_out, cmp_i_imm} cmpmux_sel_t;
    typedef enum logic [3:0] {
        rf_alu_out, rf_br_en, rf_u_imm, rf_lw, rf_pc_plus4, rf_lb, rf_lbu, rf_lh, rf_lhu
    } regfilemux_sel_t;

    typedef enum logic [2:0] {
        fetch, decode, execute, memory, writeback, halt
    } core_phase_t;

endpackage

//--- run_sim.sh
#!/bin/sh
# build the core testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_rv32i_core -f rv32i_core.f \
    --Mdir obj_dir -o tb_sim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1
grep -q "SIMULATION PASSED" sim.log && echo "test passed" || { cat sim.log; exit 1; }

//--- rv32i_core.f
+incdir+include
rtl/rv32i_pkg.sv
rtl/control_rom.sv
rtl/regfile.sv
rtl/alu.sv
rtl/apb_mem_port.sv
rtl/rv32i_core.sv
tests/tb_rv32i_core.sv

//--- tests/tb_rv32i_core.sv
//----------------------------------------
// RV32I core testbench, APB memory with
// wait states and a reference model
//----------------------------------------
`include "rv32i_settings.svh"

module tb_rv32i_core;

    localparam int BODY_LEN  = 120;
    localparam int MEM_BYTES = 16384;

    logic                         clk;
    logic                         i_reset  = 1'b1;
    logic                         i_pready = 1'b0;
    logic [31:0]                  i_prdata = 32'h0;
    logic                         o_psel, o_penable, o_pwrite, o_halted;
    logic [`RV32I_APB_ADDR_W-1:0] o_paddr;
    logic [31:0]                  o_pwdata;
    logic [3:0]                   o_pstrb;

    logic [7:0]  mem [MEM_BYTES];
    logic [7:0]  model_mem [MEM_BYTES];
    logic [31:0] model_regs [32];

    // expected bus transfers in order, fetches included
    logic [31:0] exp_addr [$];
    logic        exp_write [$];
    logic [3:0]  exp_strb [$];
    logic [31:0] exp_data [$];

    integer seed        = 32'h6ebe;
    int     errors      = 0;
    int     instr_count = 0;
    int     wait_left   = 0;
    logic   model_ready = 1'b0;

    logic                         prev_psel    = 1'b0;
    logic                         prev_pwrite  = 1'b0;
    logic [`RV32I_APB_ADDR_W-1:0] prev_paddr   = '0;
    logic [31:0]                  prev_pwdata  = '0;
    logic [3:0]                   prev_pstrb   = '0;

    rv32i_core uut (
        .clk(clk), .i_reset(i_reset), .o_psel(o_psel), .o_penable(o_penable),
        .o_pwrite(o_pwrite), .o_paddr(o_paddr), .o_pwdata(o_pwdata), .o_pstrb(o_pstrb),
        .i_prdata(i_prdata), .i_pready(i_pready), .o_halted(o_halted)
    );

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR %s got %h expected %h", name, got, exp);
        end
    endtask

    function automatic logic [31:0] rnd(input logic [31:0] n);
        return $unsigned($random(seed)) % n;
    endfunction

    // instruction encoders, R-type goes through enc_i with {funct7, rs2}
    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    task automatic put_word(input int idx, input logic [31:0] w);
        for (int k = 0; k < 4; k++) begin
            mem[4 * idx + k] = w[8*k +: 8];
        end
    endtask

    task automatic gen_program();
        logic [31:0] r, w;
        logic [4:0]  rd, rs1, rs2;
        logic [2:0]  f3;
        logic [11:0] off;
        int          skip;
        for (int a = 0; a < MEM_BYTES; a++) begin
            mem[a] = 8'(a ^ (a >> 8) ^ (a >> 13));
        end
        // x1 holds the data region base
        put_word(0, {20'h00002, 5'd1, 7'b0110111});
        for (int i = 1; i <= BODY_LEN; i++) begin
            r    = $random(seed);
            rd   = 5'(rnd(30) + 2);
            rs1  = 5'(rnd(32));
            rs2  = 5'(rnd(32));
            f3   = 3'(rnd(8));
            skip = 1 + int'(rnd(3));
            if (i + skip > BODY_LEN + 1) begin
                skip = BODY_LEN + 1 - i;
            end
            off = {4'd0, r[7:0]};
            case (rnd(10))
                0, 1: begin
                    w = enc_i({1'b0, r[0] && (f3 == 3'd0 || f3 == 3'd5), 5'd0, rs2},
                              rs1, f3, rd, 7'b0110011);
                end
                2, 3: begin
                    off = r[11:0];
                    if (f3 == 3'd1) begin
                        off = {7'd0, r[4:0]};
                    end
                    if (f3 == 3'd5) begin
                        off = {1'b0, r[10], 5'd0, r[4:0]};
                    end
                    w = enc_i(off, rs1, f3, rd, 7'b0010011);
                end
                4: w = {r[31:12], rd, 7'b0110111};
                5: w = {r[31:12], rd, 7'b0010111};
                6, 7: begin
                    // loads use lb lh lw lbu lhu, stores sb sh sw
                    f3 = 3'(rnd(5));
                    if (f3 > 3'd2) begin
                        f3 = f3 + 3'd1;
                    end
                    if (f3[1:0] == 2'd1) begin
                        off[0] = 1'b0;
                    end
                    if (f3[1:0] == 2'd2) begin
                        off[1:0] = 2'b00;
                    end
                    if (r[8] && f3 < 3'd3) begin
                        w = enc_s(off, rs2, 5'd1, f3);
                    end else begin
                        w = enc_i(off, 5'd1, f3, rd, 7'b0000011);
                    end
                end
                8: begin
                    f3 = 3'(rnd(6));
                    if (f3 > 3'd1) begin
                        f3 = f3 + 3'd2;
                    end
                    w = enc_b(13'(4 * skip), rs2, rs1, f3);
                end
                default: begin
                    // jalr target is absolute, bit 0 sometimes set
                    if (r[1]) begin
                        w = enc_j(21'(4 * skip), rd);
                    end else begin
                        w = enc_i(12'(4 * (i + skip)) | {11'd0, r[2]}, 5'd0, 3'd0, rd,
                                  7'b1100111);
                    end
                end
            endcase
            put_word(i, w);
        end
        // dump x1..x31 to 0x3000 then stop on opcode 0
        put_word(BODY_LEN + 1, {20'h00003, 5'd1, 7'b0110111});
        for (int k = 1; k < 32; k++) begin
            put_word(BODY_LEN + 1 + k, enc_s(12'(4 * k), 5'(k), 5'd1, 3'd2));
        end
        put_word(BODY_LEN + 33, 32'h0000_0000);
        for (int a = 0; a < MEM_BYTES; a++) begin
            model_mem[a] = mem[a];
        end
    endtask

    function automatic logic [31:0] model_word(input logic [31:0] addr);
        logic [13:0] a;
        a = {addr[13:2], 2'b00};
        return {model_mem[a + 14'd3], model_mem[a + 14'd2], model_mem[a + 14'd1], model_mem[a]};
    endfunction

    function automatic logic [31:0] arith(input logic [2:0] f3, input logic [31:0] a,
                                          input logic [31:0] b, input logic alt);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'd0, $signed(a) < $signed(b)};
            3'd3:    return {31'd0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic push_transfer(input logic [31:0] addr, input logic write,
                                 input logic [3:0] strb, input logic [31:0] data);
        exp_addr.push_back(addr);
        exp_write.push_back(write);
        exp_strb.push_back(strb);
        exp_data.push_back(data);
    endtask

    task automatic run_model();
        logic [31:0] pc, npc, ir, a, b, ea, word, res, imm_i, imm_s, imm_b, imm_j;
        logic [4:0]  rd;
        logic [2:0]  f3;
        logic [3:0]  strb;
        logic        taken, done;
        pc   = `RV32I_RESET_PC;
        done = 1'b0;
        for (int k = 0; k < 32; k++) begin
            model_regs[k] = '0;
        end
        while (!done && instr_count < 4096) begin
            ir = model_word(pc);
            push_transfer(pc, 1'b0, 4'h0, 32'h0);
            instr_count++;
            rd    = ir[11:7];
            f3    = ir[14:12];
            a     = model_regs[ir[19:15]];
            b     = model_regs[ir[24:20]];
            imm_i = {{20{ir[31]}}, ir[31:20]};
            imm_s = {{20{ir[31]}}, ir[31:25], ir[11:7]};
            imm_b = {{20{ir[31]}}, ir[7], ir[30:25], ir[11:8], 1'b0};
            imm_j = {{12{ir[31]}}, ir[19:12], ir[20], ir[30:21], 1'b0};
            res   = 32'h0;
            npc   = pc + 32'd4;
            case (ir[6:0])
                7'b0110111: res = {ir[31:12], 12'h000};
                7'b0010111: res = pc + {ir[31:12], 12'h000};
                7'b1101111: begin
                    res = pc + 32'd4;
                    npc = pc + imm_j;
                end
                7'b1100111: begin
                    res = pc + 32'd4;
                    npc = (a + imm_i) & ~32'h1;
                end
                7'b1100011: begin
                    case (f3)
                        3'd0:    taken = (a == b);
                        3'd1:    taken = (a != b);
                        3'd4:    taken = $signed(a) < $signed(b);
                        3'd5:    taken = $signed(a) >= $signed(b);
                        3'd6:    taken = a < b;
                        default: taken = a >= b;
                    endcase
                    if (taken) begin
                        npc = pc + imm_b;
                    end
                    rd = 5'd0;
                end
                7'b0000011: begin
                    ea = a + imm_i;
                    push_transfer({ea[31:2], 2'b00}, 1'b0, 4'h0, 32'h0);
                    word = model_word(ea) >> {ea[1:0], 3'b000};
                    case (f3)
                        3'd0:    res = {{24{word[7]}}, word[7:0]};
                        3'd1:    res = {{16{word[15]}}, word[15:0]};
                        3'd4:    res = {24'd0, word[7:0]};
                        3'd5:    res = {16'd0, word[15:0]};
                        default: res = word;
                    endcase
                end
                7'b0100011: begin
                    ea   = a + imm_s;
                    strb = (f3 == 3'd0) ? 4'b0001 : (f3 == 3'd1) ? 4'b0011 : 4'b1111;
                    strb = strb << ea[1:0];
                    word = b << {ea[1:0], 3'b000};
                    for (int k = 0; k < 4; k++) begin
                        if (strb[k]) begin
                            model_mem[{ea[13:2], 2'b00} + 14'(k)] = word[8*k +: 8];
                        end
                    end
                    push_transfer({ea[31:2], 2'b00}, 1'b1, strb, word);
                    rd = 5'd0;
                end
                7'b0010011, 7'b0110011: begin
                    res = arith(f3, a, ir[5] ? b : imm_i, ir[30] && (ir[5] || f3 == 3'd5));
                end
                default: begin
                    done = 1'b1;
                    rd   = 5'd0;
                end
            endcase
            if (rd != 5'd0) begin
                model_regs[rd] = res;
            end
            pc = npc;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // APB completer with 0 to 3 wait states per access
    always @(posedge clk) begin
        logic [13:0] a;
        a = {o_paddr[13:2], 2'b00};
        if (o_psel && !o_penable) begin
            wait_left = int'(rnd(4));
            i_pready <= (wait_left == 0);
            i_prdata <= {mem[a + 14'd3], mem[a + 14'd2], mem[a + 14'd1], mem[a]};
        end else if (o_psel && !i_pready) begin
            wait_left--;
            i_pready <= (wait_left == 0);
        end else begin
            if (o_psel && o_pwrite) begin
                for (int k = 0; k < 4; k++) begin
                    if (o_pstrb[k]) begin
                        mem[a + 14'(k)] = o_pwdata[8*k +: 8];
                    end
                end
            end
            i_pready <= 1'b0;
        end
    end

    // protocol checks and transfer compare against the model
    always @(posedge clk) begin
        logic [3:0]  strb;
        logic [31:0] mask;
        if (!i_reset) begin
            if (o_penable) begin
                check_value("o_psel in access", 32'(o_psel), 32'd1);
                check_value("o_psel before access", 32'(prev_psel), 32'd1);
                check_value("o_paddr held", 32'(o_paddr), 32'(prev_paddr));
                check_value("o_pwrite held", 32'(o_pwrite), 32'(prev_pwrite));
                check_value("o_pwdata held", o_pwdata, prev_pwdata);
                check_value("o_pstrb held", 32'(o_pstrb), 32'(prev_pstrb));
            end else if (o_psel) begin
                check_value("o_psel before setup", 32'(prev_psel), 32'd0);
                if (exp_addr.size() == 0) begin
                    errors++;
                    $display("unexpected bus transfer at %h after the program ended", o_paddr);
                end else begin
                    strb = exp_strb.pop_front();
                    mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
                    check_value("o_paddr", 32'(o_paddr), exp_addr.pop_front());
                    check_value("o_pwrite", 32'(o_pwrite), 32'(exp_write.pop_front()));
                    check_value("o_pstrb", 32'(o_pstrb), 32'(strb));
                    check_value("o_pwdata", o_pwdata & mask, exp_data.pop_front() & mask);
                end
            end
        end
        prev_psel   = o_psel;
        prev_pwrite = o_pwrite;
        prev_paddr  = o_paddr;
        prev_pwdata = o_pwdata;
        prev_pstrb  = o_pstrb;
    end

    initial begin
        logic [31:0] dumped;
        logic [13:0] a;
        gen_program();
        run_model();
        model_ready = 1'b1;
        repeat (2) @(posedge clk);
        i_reset <= 1'b0;
        @(negedge clk);
        check_value("o_psel", 32'(o_psel), 32'd0);
        check_value("o_halted", 32'(o_halted), 32'd0);
        wait (o_halted === 1'b1);
        // bus must stay quiet once halted
        repeat (8) @(posedge clk);
        check_value("o_halted", 32'(o_halted), 32'd1);
        check_value("transfers left", 32'(exp_addr.size()), 32'd0);
        for (int k = 1; k < 32; k++) begin
            a      = 14'(32'h3000 + 4 * k);
            dumped = {mem[a + 14'd3], mem[a + 14'd2], mem[a + 14'd1], mem[a]};
            check_value($sformatf("x%0d", k), dumped, model_regs[k]);
        end
        $display("errors: %0d, instructions: %0d", errors, instr_count);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // watchdog, 40 cycles per executed instruction
    initial begin
        wait (model_ready);
        repeat (instr_count * 40 + 10) @(posedge clk);
        $display("core did not halt in time");
        $display("errors: %0d, instructions: %0d", errors, instr_count);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule
